//--- fft_col_ctrl.f
+incdir+.
fft_col_pkg.sv
transpose_addr_counter.sv
row_sequencer.sv
lane_reader.sv
result_writer.sv
fft_col_ctrl.sv
tb_fft_col_ctrl.sv

//--- Makefile
TOP = tb_fft_col_ctrl

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f fft_col_ctrl.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- fft_col_vectors.txt
// Each line: FFT result word data[63:0] (16 hex digits), then packed word [31:0] (8 hex digits)
// Packed word is data[60:45] above data[28:13]
E0001FFFE0001FFF00000000
1FFFE0001FFFE000FFFFFFFF
024680000ACF000012345678
E2469FFFEACF1FFF12345678
100000000000200080000001
000020001000000000018000
155540000AAAA000AAAA5555
0AAAA000155540005555AAAA
1BD5A00017DDE000DEADBEEF
FBD5BFFFF7DDFFFFDEADBEEF
01E1E0001E1E00000F0FF0F0
EFFFFFFFE0001FFF7FFF0000
000000000FFFE00000007FFF
195FC0001E01A000CAFEF00D
0024600008ACE00001234567
1135600019BDE00089ABCDEF
F1357FFFF9BDFFFF89ABCDEF
E0003FFFE0003FFF00010001
080000000400000040002000
FFFFFFFFE0001FFFFFFF0000
000000001FFFE0000000FFFF
078780001878600003C3CC3C3

//--- tb_fft_col_ctrl.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module tb_fft_col_ctrl;

    localparam int LANES     = `FFT_COL_LANES;
    localparam int DEPTH     = 1 << `FFT_COL_ADDR_W;
    localparam int FILE_VEC  = 22;
    // The final line of the vector file is not a well-formed pair
    localparam int NUM_VEC   = 21;
    localparam int LANE_SKEW = 5;
    localparam int TIMEOUT   = 20000;

    logic                                       s_axi_aclk;
    logic                                       s_axi_aresetn;
    logic                                       frame_start;
    wire                                        frame_done;
    wire fft_col_pkg::fft_stream_t [LANES-1:0]  fft_in;
    fft_col_pkg::fft_stream_t [LANES-1:0]       fft_out;
    wire fft_col_pkg::bram_rd_t [LANES-1:0]     bram_rd;
    logic [LANES-1:0][`FFT_COL_SAMPLE_W-1:0]    bram_rddata;
    wire fft_col_pkg::bram_wr_t [LANES-1:0]     bram_wr;
    fft_col_pkg::bram_rd_t [LANES-1:0]          rd_q;

    logic [95:0] vectors [FILE_VEC];
    logic [11:0] exp_rdaddr [LANES];
    logic [11:0] prev_rdaddr [LANES];
    logic [11:0] bank_addr [LANES];
    logic [11:0] exp_wraddr [LANES];
    logic        prev_rden [LANES];
    logic        bank_seen [LANES];
    logic        prev_drv [LANES];
    int          burst_cnt [LANES];
    int          beat_cnt [LANES];
    int          read_total [LANES];
    int          first_rd [LANES];
    int          write_total [LANES];
    int          done_cnt;
    int          cycle;
    logic [31:0] lfsr;

    fft_col_ctrl i_fft_col_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .frame_start   (frame_start),
        .frame_done    (frame_done),
        .fft_in        (fft_in),
        .fft_out       (fft_out),
        .bram_rd       (bram_rd),
        .bram_rddata   (bram_rddata),
        .bram_wr       (bram_wr)
    );

    initial begin
        s_axi_aclk = 1'b0;
        forever #4 s_axi_aclk = ~s_axi_aclk;
    end

    // Transposed column order
    function automatic logic [11:0] next_addr(input logic [11:0] a);
        if (&a[11:5]) begin
            return {7'd0, a[4:0] + 5'd1};
        end else if (&a[11:7]) begin
            return {5'd0, a[6:0]} + 12'd32;
        end
        return a + 12'd128;
    endfunction

    function automatic logic [63:0] bank_word(input logic [1:0] b, input logic [11:0] a);
        return {8'hb0, 6'd0, b, 36'd0, a};
    endfunction

    // Each lane walks the vectors from its own offset
    function automatic int vector_index(input int beat, input int lane);
        return (beat + lane * LANE_SKEW) % NUM_VEC;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bank model returning data one cycle after rden
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge s_axi_aclk) begin
        rd_q <= s_axi_aresetn ? bram_rd : '0;
    end

    always @(negedge s_axi_aclk) begin
        for (int b = 0; b < LANES; b++) begin
            if (rd_q[b].rden) begin
                bram_rddata[b] = bank_word(2'(b), rd_q[b].rdaddr);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checker
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge s_axi_aclk) begin : monitor
        logic [1:0]  sel;
        logic [63:0] exp_data;
        int          src;
        if (!s_axi_aresetn) begin
            for (int k = 0; k < LANES; k++) begin
                exp_rdaddr[k]  = '0;
                prev_rdaddr[k] = '0;
                bank_addr[k]   = '0;
                exp_wraddr[k]  = '0;
                prev_rden[k]   = 1'b0;
                bank_seen[k]   = 1'b0;
                prev_drv[k]    = 1'b0;
                burst_cnt[k]   = 0;
                beat_cnt[k]    = 0;
                read_total[k]  = 0;
                first_rd[k]    = -1;
                write_total[k] = 0;
            end
            done_cnt = 0;
            cycle    = 0;
        end else begin
            cycle++;
            for (int k = 0; k < LANES; k++) begin
                check_equal(64'(fft_in[k].valid), 64'(prev_rden[k]), "fft_in valid");
                if (fft_in[k].valid) begin
                    beat_cnt[k]++;
                    sel = prev_rdaddr[k][6:5];
                    exp_data = bank_seen[sel] ? bank_word(sel, bank_addr[sel]) : 64'd0;
                    check_equal(fft_in[k].data, exp_data, "fft_in data");
                end
                check_equal(64'(fft_in[k].last),
                            64'(prev_rden[k] && beat_cnt[k] == `FFT_COL_FFT_LEN),
                            "fft_in last");
                if (beat_cnt[k] == `FFT_COL_FFT_LEN) begin
                    beat_cnt[k] = 0;
                end
                if (bram_rd[k].rden) begin
                    check_equal(64'(read_total[k] < DEPTH), 64'd1, "read after frame end");
                    check_equal(64'(bram_rd[k].rdaddr), 64'(exp_rdaddr[k]), "read address");
                    if (first_rd[k] < 0) begin
                        first_rd[k] = cycle;
                        if (k > 0) begin
                            check_equal(64'(first_rd[k] - first_rd[k-1]),
                                        64'(`FFT_COL_LANE_STAGGER), "lane stagger");
                        end
                    end
                    exp_rdaddr[k] = next_addr(exp_rdaddr[k]);
                    burst_cnt[k]++;
                    read_total[k]++;
                end else if (prev_rden[k]) begin
                    check_equal(64'(burst_cnt[k]), 64'(`FFT_COL_FFT_LEN), "burst length");
                    burst_cnt[k] = 0;
                end
                prev_rden[k]   = bram_rd[k].rden;
                prev_rdaddr[k] = bram_rd[k].rdaddr;
                check_equal(64'(bram_wr[k].wren), 64'(prev_drv[k]), "write enable");
                if (bram_wr[k].wren) begin
                    src = int'(exp_wraddr[k][6:5]);
                    check_equal(64'(bram_wr[k].wraddr), 64'(exp_wraddr[k]), "write address");
                    check_equal(64'(bram_wr[k].wrdata),
                                64'(vectors[vector_index(write_total[k], src)][31:0]),
                                "write data");
                    exp_wraddr[k] = next_addr(exp_wraddr[k]);
                    write_total[k]++;
                end
                prev_drv[k] = fft_out[k].valid;
            end
            // Bank outputs seen next cycle
            for (int b = 0; b < LANES; b++) begin
                if (bram_rd[b].rden) begin
                    bank_addr[b] = bram_rd[b].rdaddr;
                    bank_seen[b] = 1'b1;
                end
            end
            check_equal(64'(frame_done),
                        64'(bram_wr[LANES-1].wren && write_total[LANES-1] == DEPTH),
                        "frame_done");
            if (frame_done) begin
                check_equal(64'(bram_wr[LANES-1].wraddr), 64'hfff, "final write address");
                done_cnt++;
            end
        end
    end

    task automatic drive_results();
        int gap;
        for (int n = 0; n < DEPTH; n++) begin
            for (int k = 0; k < LANES; k++) begin
                fft_out[k].valid = 1'b1;
                fft_out[k].data  = vectors[vector_index(n, k)][95:32];
            end
            @(negedge s_axi_aclk);
            for (int k = 0; k < LANES; k++) begin
                fft_out[k].valid = 1'b0;
            end
            gap = next_bit() ? 2 : 0;
            if (next_bit()) begin
                gap++;
            end
            repeat (gap) @(negedge s_axi_aclk);
        end
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (read_total[LANES-1] != DEPTH || burst_cnt[LANES-1] != 0) begin
            if (n == TIMEOUT) begin
                $display("Timed out waiting for the read bursts to finish");
                $display("Done: errors found");
                $fatal(1, "timeout");
            end
            @(negedge s_axi_aclk);
            n++;
        end
    endtask

    task automatic wait_writes_done();
        int n;
        n = 0;
        while (write_total[LANES-1] != DEPTH) begin
            if (n == TIMEOUT) begin
                $display("Timed out waiting for the result writes");
                $display("Done: errors found");
                $fatal(1, "timeout");
            end
            @(negedge s_axi_aclk);
            n++;
        end
    endtask

    initial begin
        $readmemh("fft_col_vectors.txt", vectors);
        s_axi_aresetn = 1'b0;
        frame_start   = 1'b0;
        fft_out       = '0;
        bram_rddata   = '0;
        lfsr          = 32'hf76000e3;
        repeat (8) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;

        // Quiet before the frame starts
        repeat (6) begin
            @(negedge s_axi_aclk);
            for (int k = 0; k < LANES; k++) begin
                check_equal(64'(bram_rd[k].rden), 64'd0, "idle rden");
                check_equal(64'(fft_in[k].valid), 64'd0, "idle fft_in valid");
                check_equal(64'(bram_wr[k].wren), 64'd0, "idle wren");
            end
            check_equal(64'(frame_done), 64'd0, "idle frame_done");
        end

        frame_start = 1'b1;
        @(negedge s_axi_aclk);
        frame_start = 1'b0;
        fork
            wait_reads_done();
            begin
                drive_results();
                wait_writes_done();
            end
        join
        repeat (300) @(negedge s_axi_aclk);
        for (int k = 0; k < LANES; k++) begin
            check_equal(64'(read_total[k]), 64'(DEPTH), "reads per lane");
        end
        check_equal(64'(done_cnt), 64'd1, "frame_done pulses");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- fft_col_ctrl.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module fft_col_ctrl (
    input  wire                                               s_axi_aclk,
    input  wire                                               s_axi_aresetn,
    input  wire                                               frame_start,
    output wire                                               frame_done,
    output wire fft_col_pkg::fft_stream_t [`FFT_COL_LANES-1:0] fft_in,
    input  wire fft_col_pkg::fft_stream_t [`FFT_COL_LANES-1:0] fft_out,
    output wire fft_col_pkg::bram_rd_t [`FFT_COL_LANES-1:0]    bram_rd,
    input  wire [`FFT_COL_LANES-1:0][`FFT_COL_SAMPLE_W-1:0]   bram_rddata,
    output wire fft_col_pkg::bram_wr_t [`FFT_COL_LANES-1:0]    bram_wr
);

    wire [`FFT_COL_LANES-1:0] lane_start;

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    row_sequencer i_row_sequencer (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .frame_start   (frame_start),
        .start         (lane_start)
    );

    for (genvar k = 0; k < `FFT_COL_LANES; k++) begin : g_lane
        lane_reader i_lane_reader (
            .s_axi_aclk    (s_axi_aclk),
            .s_axi_aresetn (s_axi_aresetn),
            .start         (lane_start[k]),
            .bram_rddata   (bram_rddata),
            .rd            (bram_rd[k]),
            .fft_in        (fft_in[k])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    result_writer i_result_writer (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .fft_out       (fft_out),
        .wr            (bram_wr),
        .frame_done    (frame_done)
    );

endmodule

`default_nettype wire

//--- result_writer.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module result_writer (
    input  wire                                               s_axi_aclk,
    input  wire                                               s_axi_aresetn,
    input  wire fft_col_pkg::fft_stream_t [`FFT_COL_LANES-1:0] fft_out,
    output fft_col_pkg::bram_wr_t [`FFT_COL_LANES-1:0]         wr,
    output logic                                              frame_done
);

    localparam int SEL_W    = $clog2(`FFT_COL_LANES);
    localparam int BANK_LSB = $clog2(`FFT_COL_FFT_LEN / `FFT_COL_LANES);

    logic [`FFT_COL_LANES-1:0][`FFT_COL_PIXEL_W-1:0] packed_res;
    logic [`FFT_COL_LANES-1:0][`FFT_COL_ADDR_W-1:0]  sel_addr;
    logic [`FFT_COL_LANES-1:0]                       wren_q;
    logic [`FFT_COL_LANES-1:0][`FFT_COL_ADDR_W-1:0]  wraddr_q;
    logic [`FFT_COL_LANES-1:0][`FFT_COL_PIXEL_W-1:0] wrdata_q;

    // 16-bit real over 16-bit imaginary
    always_comb begin
        for (int k = 0; k < `FFT_COL_LANES; k++) begin
            packed_res[k] = {fft_out[k].data[`FFT_COL_RE_MSB:`FFT_COL_RE_LSB],
                             fft_out[k].data[`FFT_COL_IM_MSB:`FFT_COL_IM_LSB]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write address per bank, stepped by that lane's result beats
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < `FFT_COL_LANES; b++) begin : g_bank
        transpose_addr_counter i_wr_addr (
            .s_axi_aclk    (s_axi_aclk),
            .s_axi_aresetn (s_axi_aresetn),
            .step          (fft_out[b].valid),
            .addr          (sel_addr[b]),
            .burst_end     ()
        );
    end

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wren_q   <= '0;
            wraddr_q <= '0;
        end else begin
            for (int b = 0; b < `FFT_COL_LANES; b++) begin
                wren_q[b]   <= fft_out[b].valid;
                wraddr_q[b] <= sel_addr[b];
            end
        end
    end

    // Source lane named by the bank field of the write address
    always_ff @(posedge s_axi_aclk) begin
        for (int b = 0; b < `FFT_COL_LANES; b++) begin
            wrdata_q[b] <= packed_res[sel_addr[b][BANK_LSB +: SEL_W]];
        end
    end

    always_comb begin
        for (int b = 0; b < `FFT_COL_LANES; b++) begin
            wr[b].wren   = wren_q[b];
            wr[b].wraddr = wraddr_q[b];
            wr[b].wrdata = wrdata_q[b];
        end
    end

    // Last bank's final address closes the frame
    assign frame_done = wren_q[`FFT_COL_LANES-1] && (&wraddr_q[`FFT_COL_LANES-1]);

endmodule

`default_nettype wire

//--- lane_reader.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module lane_reader (
    input  wire                                              s_axi_aclk,
    input  wire                                              s_axi_aresetn,
    input  wire                                              start,
    input  wire [`FFT_COL_LANES-1:0][`FFT_COL_SAMPLE_W-1:0] bram_rddata,
    output fft_col_pkg::bram_rd_t                            rd,
    output fft_col_pkg::fft_stream_t                         fft_in
);

    localparam int SEL_W    = $clog2(`FFT_COL_LANES);
    localparam int BANK_LSB = $clog2(`FFT_COL_FFT_LEN / `FFT_COL_LANES);

    fft_col_pkg::rd_state_e     state;
    logic [`FFT_COL_ADDR_W-1:0] rdaddr;
    logic                       rden;
    logic                       burst_end;
    logic [SEL_W-1:0]           bank_sel;
    logic                       in_valid;
    logic                       in_last;

    assign rden = (state == fft_col_pkg::RD_BURST);

    transpose_addr_counter i_rd_addr (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .step          (rden),
        .addr          (rdaddr),
        .burst_end     (burst_end)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Burst of one transform, 128 reads
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state <= fft_col_pkg::RD_IDLE;
        end else begin
            case (state)
                fft_col_pkg::RD_IDLE: begin
                    if (start) begin
                        state <= fft_col_pkg::RD_BURST;
                    end
                end
                fft_col_pkg::RD_BURST: begin
                    if (burst_end) begin
                        state <= fft_col_pkg::RD_IDLE;
                    end
                end
                default: state <= fft_col_pkg::RD_IDLE;
            endcase
        end
    end

    // Data returns one cycle after the read, so track its bank
    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            bank_sel <= '0;
            in_valid <= 1'b0;
            in_last  <= 1'b0;
        end else begin
            bank_sel <= rdaddr[BANK_LSB +: SEL_W];
            in_valid <= rden;
            in_last  <= burst_end;
        end
    end

    always_comb begin
        rd.rden      = rden;
        rd.rdaddr    = rdaddr;
        fft_in.valid = in_valid;
        fft_in.last  = in_last;
        fft_in.data  = bram_rddata[bank_sel];
    end

    a_last_in_burst: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        fft_in.last |-> fft_in.valid
    ) else $error("last outside a valid beat");

endmodule

`default_nettype wire

//--- row_sequencer.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module row_sequencer (
    input  wire                       s_axi_aclk,
    input  wire                       s_axi_aresetn,
    input  wire                       frame_start,
    output logic [`FFT_COL_LANES-1:0] start
);

    localparam int PIX_W = $clog2(`FFT_COL_ROW_PERIOD);
    localparam int ROW_W = $clog2(`FFT_COL_ROWS);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(`FFT_COL_ROW_PERIOD - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`FFT_COL_ROWS - 1);

    fft_col_pkg::seq_state_e state;
    logic [PIX_W-1:0]        pix;
    logic [ROW_W-1:0]        row;
    logic                    row_end;
    logic                    frame_end;

    assign row_end   = (pix == PIX_LAST);
    assign frame_end = row_end && (row == ROW_LAST);

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state <= fft_col_pkg::SEQ_IDLE;
            pix   <= '0;
            row   <= '0;
        end else begin
            if (frame_start) begin
                state <= fft_col_pkg::SEQ_RUN;
            end else if (frame_end) begin
                state <= fft_col_pkg::SEQ_IDLE;
            end
            if (state == fft_col_pkg::SEQ_RUN) begin
                pix <= row_end ? '0 : pix + 1'b1;
                if (row_end) begin
                    row <= (row == ROW_LAST) ? '0 : row + 1'b1;
                end
            end else begin
                pix <= '0;
                row <= '0;
            end
        end
    end

    // Lane k starts one stagger after lane k-1
    always_comb begin
        for (int k = 0; k < `FFT_COL_LANES; k++) begin
            start[k] = (pix == PIX_W'(1 + k * `FFT_COL_LANE_STAGGER));
        end
    end

    a_no_restart: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (state == fft_col_pkg::SEQ_RUN) |-> !frame_start
    ) else $error("frame_start during a running frame");

endmodule

`default_nettype wire

//--- transpose_addr_counter.sv
`default_nettype none
`timescale 1ns/100ps
`include "fft_col_defines.svh"

module transpose_addr_counter (
    input  wire                        s_axi_aclk,
    input  wire                        s_axi_aresetn,
    input  wire                        step,
    output logic [`FFT_COL_ADDR_W-1:0] addr,
    output logic                       burst_end
);

    // Row stride is one transform and a bank holds a quarter column
    localparam logic [`FFT_COL_ADDR_W-1:0] ROW_STEP  = `FFT_COL_FFT_LEN;
    localparam logic [`FFT_COL_ADDR_W-1:0] BANK_STEP = `FFT_COL_FFT_LEN / `FFT_COL_LANES;
    localparam int ROW_LSB  = $clog2(`FFT_COL_FFT_LEN);
    localparam int BANK_LSB = $clog2(`FFT_COL_FFT_LEN / `FFT_COL_LANES);

    logic [`FFT_COL_ADDR_W-1:0] addr_next;
    logic                       col_end;

    assign col_end   = &addr[`FFT_COL_ADDR_W-1:ROW_LSB];
    assign burst_end = &addr[`FFT_COL_ADDR_W-1:BANK_LSB];

    always_comb begin
        if (burst_end) begin
            // Step to the next column and wrap after the last one
            addr_next = {{(`FFT_COL_ADDR_W-BANK_LSB){1'b0}}, addr[BANK_LSB-1:0] + 1'b1};
        end else if (col_end) begin
            addr_next = {{(`FFT_COL_ADDR_W-ROW_LSB){1'b0}}, addr[ROW_LSB-1:0]} + BANK_STEP;
        end else begin
            addr_next = addr + ROW_STEP;
        end
    end

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            addr <= '0;
        end else if (step) begin
            addr <= addr_next;
        end
    end

    a_column_within_burst: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        step && !burst_end |=> $stable(addr[BANK_LSB-1:0])
    ) else $error("column changed inside a burst");

endmodule

`default_nettype wire

//--- fft_col_pkg.sv
`default_nettype none
`include "fft_col_defines.svh"

package fft_col_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream and block-RAM bundles
    ////////////////////////////////////////////////////////////////////////////

    // One beat toward or from an FFT core
    typedef struct packed {
        logic                         valid;
        logic                         last;
        logic [`FFT_COL_SAMPLE_W-1:0] data;
    } fft_stream_t;

    // Read request of one bank
    typedef struct packed {
        logic                       rden;
        logic [`FFT_COL_ADDR_W-1:0] rdaddr;
    } bram_rd_t;

    // Write of one bank
    typedef struct packed {
        logic                        wren;
        logic [`FFT_COL_ADDR_W-1:0]  wraddr;
        logic [`FFT_COL_PIXEL_W-1:0] wrdata;
    } bram_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // States
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_e;

endpackage

`default_nettype wire

//--- fft_col_defines.svh
`ifndef FFT_COL_DEFINES_SVH
`define FFT_COL_DEFINES_SVH

// Lanes and banks
`define FFT_COL_LANES        4
`define FFT_COL_ADDR_W       12
`define FFT_COL_SAMPLE_W     64
`define FFT_COL_PIXEL_W      32

// Frame timing
`define FFT_COL_FFT_LEN      128
`define FFT_COL_ROW_PERIOD   130
`define FFT_COL_ROWS         32
`define FFT_COL_LANE_STAGGER 32

// Result packing, real over imaginary
`define FFT_COL_RE_MSB       60
`define FFT_COL_RE_LSB       45
`define FFT_COL_IM_MSB       28
`define FFT_COL_IM_LSB       13

`endif
